// ==== Makefile ====
SRCS := $(shell grep -v '^+' files.f)

.PHONY: run clean

run: obj_dir/Vtb_mat_ctrl
	@out=$$(./obj_dir/Vtb_mat_ctrl); echo "$$out"; \
	echo "$$out" | grep -qx 'Result: PASSED'

obj_dir/Vtb_mat_ctrl: files.f $(SRCS) logic/mat_config.svh
	verilator --binary --timing --assert -j 0 -f files.f --top-module tb_mat_ctrl

clean:
	rm -rf obj_dir

// ==== files.f ====
+incdir+logic
logic/ctrl_pkg.sv
logic/ledger_pkg.sv
logic/ledger_if.sv
logic/btn_edge.sv
logic/shape_ledger.sv
logic/operand_check.sv
logic/mode_sequencer.sv
logic/mat_ctrl_top.sv
verif/tb_mat_ctrl.sv

// ==== logic/btn_edge.sv ====
module btn_edge (
    input  logic clk,
    input  logic rst_n,
    input  logic i_btn,
    output logic o_pulse
);

    logic sync_q1;
    logic sync_q2;
    logic dly_q;

    // two stage sync, then one delay stage for the edge
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            sync_q1 <= 1'b0;
            sync_q2 <= 1'b0;
            dly_q   <= 1'b0;
        end else begin
            sync_q1 <= i_btn;
            sync_q2 <= sync_q1;
            dly_q   <= sync_q2;
        end
    end

    assign o_pulse = sync_q2 & ~dly_q; // rising level only

endmodule

// ==== logic/ctrl_pkg.sv ====
package ctrl_pkg;

    // controller states
    typedef enum logic [3:0] {
        ST_IDLE          = 4'd0,
        ST_INPUT         = 4'd1,
        ST_SELECT_OP     = 4'd2,
        ST_GET_DIM       = 4'd3,
        ST_FILTER        = 4'd4,
        ST_GET_ID        = 4'd5,
        ST_CHECK         = 4'd6,
        ST_EXECUTE       = 4'd7,
        ST_WAIT_DECISION = 4'd8,
        ST_ERROR         = 4'd9
    } ctrl_state_e;

    // operation codes, unlisted codes behave as matmul
    typedef enum logic [2:0] {
        OP_TRANSPOSE = 3'd0,
        OP_ADD       = 3'd1,
        OP_MATMUL    = 3'd3
    } op_e;

endpackage

// ==== logic/ledger_if.sv ====
interface ledger_if import ledger_pkg::*;;

    // sequencer side
    shape_t q_shape;   // shape being looked up
    logic   alloc;     // input allocation
    logic   commit;    // calc result allocation
    logic   rollback;  // undo last alloc

    // ledger side
    logic   hit;
    lidx_t  hit_idx;   // highest matching entry
    addr_t  slot_addr; // where the next copy goes
    addr_t  hit_start;
    vcnt_t  hit_cnt;

    modport seq (
        output q_shape, alloc, commit, rollback,
        input  hit, hit_idx, slot_addr, hit_start, hit_cnt
    );

    modport ledger (
        input  q_shape, alloc, commit, rollback,
        output hit, hit_idx, slot_addr, hit_start, hit_cnt
    );

endinterface

// ==== logic/ledger_pkg.sv ====
`include "mat_config.svh"

package ledger_pkg;

    typedef logic [`MAT_DIM_W-1:0]  dim_t;
    typedef logic [`MAT_ADDR_W-1:0] addr_t;

    typedef struct packed {
        dim_t m; // rows
        dim_t n; // cols
    } shape_t;

    typedef logic [4:0] lidx_t; // ledger index / types count
    typedef logic [1:0] vcnt_t; // per shape, saturates at 2
    typedef logic [7:0] cnt_t;  // total matrices stored

endpackage

// ==== logic/mat_config.svh ====
`ifndef MAT_CONFIG_SVH
`define MAT_CONFIG_SVH

// ==============================
// ledger sizing
// ==============================
`define MAT_MAX_TYPES 25 // shape entries in the ledger

// datapath widths
`define MAT_DIM_W  8 // one dimension
`define MAT_ADDR_W 9 // storage address

`endif

// ==== logic/mat_ctrl_top.sv ====
`include "mat_config.svh"

module mat_ctrl_top import ctrl_pkg::*, ledger_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [7:0]  i_sw,
    input  logic        i_btn_confirm,
    input  logic        i_btn_retry,
    input  logic        i_btn_menu,
    input  logic        i_dims_valid,
    input  dim_t        i_dim_m,
    input  dim_t        i_dim_n,
    input  logic        i_rx_done,
    input  logic        i_error_flag,
    input  logic        i_timeout,
    input  logic        i_id_valid,
    input  logic [7:0]  i_id_val,
    input  logic        i_calc_done,
    output logic        o_en_input,
    output logic [1:0]  o_task_mode,
    output logic        o_addr_ready,
    output addr_t       o_base_addr,
    output logic        o_start_calc,
    output op_e         o_op_code,
    output addr_t       o_op1_addr,
    output addr_t       o_op2_addr,
    output addr_t       o_res_addr,
    output ctrl_state_e o_state,
    output logic        o_logic_error,
    output lidx_t       o_types_count,
    output cnt_t        o_total_count
);

    logic   confirm_p, retry_p, menu_p;
    logic   load1, load2, legal;
    shape_t res_shape;

    ledger_if lif_0 ();

    // ==============================
    // buttons
    // ==============================
    btn_edge u_btn_confirm (.clk(clk), .rst_n(rst_n), .i_btn(i_btn_confirm), .o_pulse(confirm_p));
    btn_edge u_btn_retry   (.clk(clk), .rst_n(rst_n), .i_btn(i_btn_retry),   .o_pulse(retry_p));
    btn_edge u_btn_menu    (.clk(clk), .rst_n(rst_n), .i_btn(i_btn_menu),    .o_pulse(menu_p));

    mode_sequencer u_seq (
        .clk(clk), .rst_n(rst_n),
        .i_sw(i_sw),
        .i_confirm(confirm_p), .i_retry(retry_p), .i_menu(menu_p),
        .i_dims_valid(i_dims_valid),
        .i_dim({i_dim_m, i_dim_n}),
        .i_rx_done(i_rx_done), .i_error_flag(i_error_flag), .i_timeout(i_timeout),
        .i_id_valid(i_id_valid), .i_id_val(i_id_val),
        .i_calc_done(i_calc_done),
        .i_legal(legal), .i_res_shape(res_shape),
        .lif(lif_0),
        .o_op(o_op_code), .o_load1(load1), .o_load2(load2),
        .o_en_input(o_en_input), .o_task_mode(o_task_mode),
        .o_addr_ready(o_addr_ready), .o_base_addr(o_base_addr),
        .o_start_calc(o_start_calc),
        .o_op1_addr(o_op1_addr), .o_op2_addr(o_op2_addr), .o_res_addr(o_res_addr),
        .o_state(o_state), .o_logic_error(o_logic_error)
    );

    // operand shapes come from the current ledger query
    operand_check u_check (
        .clk(clk), .rst_n(rst_n),
        .i_op(o_op_code), .i_load1(load1), .i_load2(load2),
        .i_shape(lif_0.q_shape),
        .o_legal(legal), .o_res_shape(res_shape)
    );

    shape_ledger u_ledger (
        .clk(clk), .rst_n(rst_n),
        .lif(lif_0),
        .o_types_count(o_types_count), .o_total_count(o_total_count)
    );

endmodule

// ==== logic/mode_sequencer.sv ====
`include "mat_config.svh"

module mode_sequencer import ctrl_pkg::*, ledger_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [7:0]  i_sw,
    input  logic        i_confirm,
    input  logic        i_retry,
    input  logic        i_menu,
    input  logic        i_dims_valid,
    input  shape_t      i_dim,
    input  logic        i_rx_done,
    input  logic        i_error_flag,
    input  logic        i_timeout,
    input  logic        i_id_valid,
    input  logic [7:0]  i_id_val,
    input  logic        i_calc_done,
    input  logic        i_legal,
    input  shape_t      i_res_shape,
    ledger_if.seq       lif,
    output op_e         o_op,
    output logic        o_load1,
    output logic        o_load2,
    output logic        o_en_input,
    output logic [1:0]  o_task_mode,
    output logic        o_addr_ready,
    output addr_t       o_base_addr,
    output logic        o_start_calc,
    output addr_t       o_op1_addr,
    output addr_t       o_op2_addr,
    output addr_t       o_res_addr,
    output ctrl_state_e o_state,
    output logic        o_logic_error
);

    localparam int PW = 2 * `MAT_DIM_W;

    ctrl_state_e   state, next_state;
    ctrl_state_e   r_retry_state; // mode picked in idle
    op_e           r_op;
    logic          r_stage;       // 0 first operand, 1 second
    logic          r_alloc_done;
    logic          r_alloc_open;
    shape_t        r_shape;
    logic          id_ok;
    logic          need_second;
    logic [PW-1:0] mat_size;
    logic [PW-1:0] id_offset;
    addr_t         op_addr;

    // ==============================
    // ledger query and strobes
    // ==============================
    always_comb begin
        case (state)
            ST_INPUT:             lif.q_shape = i_dim;
            ST_CHECK, ST_EXECUTE: lif.q_shape = i_res_shape; // result slot
            default:              lif.q_shape = r_shape;
        endcase
    end

    assign lif.alloc    = (state == ST_INPUT) && i_dims_valid && !r_alloc_done;
    assign lif.rollback = (state == ST_INPUT) && i_error_flag && r_alloc_open && !i_rx_done;
    assign lif.commit   = (state == ST_EXECUTE) && i_calc_done;

    // operand selection
    assign id_ok       = i_id_valid && (i_id_val != 8'd0) && (i_id_val <= {6'd0, lif.hit_cnt});
    assign need_second = !r_stage && (r_op != OP_TRANSPOSE);
    assign mat_size    = lif.q_shape.m * lif.q_shape.n;
    assign id_offset   = (PW'(i_id_val) - PW'(1)) * mat_size;
    assign op_addr     = lif.hit_start + id_offset[`MAT_ADDR_W-1:0];

    assign o_load1 = (state == ST_GET_ID) && id_ok && !r_stage;
    assign o_load2 = (state == ST_GET_ID) && id_ok && r_stage;

    assign o_en_input  = (state == ST_INPUT) || (state == ST_GET_DIM) || (state == ST_GET_ID);
    assign o_task_mode = (state == ST_GET_DIM) ? 2'd1 :
                         (state == ST_GET_ID)  ? 2'd2 : 2'd0;
    assign o_op    = r_op;
    assign o_state = state;

    // ==============================
    // next state
    // ==============================
    always_comb begin
        next_state = state;
        if (i_menu && state != ST_IDLE) begin
            next_state = ST_IDLE;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (i_confirm && i_sw[1:0] == 2'b00) next_state = ST_INPUT;
                    if (i_confirm && i_sw[1:0] == 2'b10) next_state = ST_SELECT_OP;
                end
                ST_INPUT: begin
                    if (i_rx_done)      next_state = ST_WAIT_DECISION;
                    else if (i_timeout) next_state = ST_ERROR;
                end
                ST_SELECT_OP:     if (i_confirm) next_state = ST_GET_DIM;
                ST_GET_DIM:       if (i_dims_valid) next_state = ST_FILTER;
                ST_FILTER:        next_state = lif.hit ? ST_GET_ID : ST_GET_DIM;
                ST_GET_ID:        if (id_ok) next_state = need_second ? ST_GET_DIM : ST_CHECK;
                ST_CHECK:         next_state = i_legal ? ST_EXECUTE : ST_SELECT_OP;
                ST_EXECUTE:       if (i_calc_done) next_state = ST_WAIT_DECISION;
                ST_WAIT_DECISION: begin
                    if (i_confirm)    next_state = ST_IDLE;
                    else if (i_retry) next_state = r_retry_state;
                end
                ST_ERROR:         if (i_confirm) next_state = ST_IDLE;
                default:          next_state = ST_IDLE;
            endcase
        end
    end

    // ==============================
    // control registers
    // ==============================
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state         <= ST_IDLE;
            r_retry_state <= ST_INPUT;
            r_op          <= OP_TRANSPOSE;
            r_stage       <= 1'b0;
            r_alloc_done  <= 1'b0;
            r_alloc_open  <= 1'b0;
            o_addr_ready  <= 1'b0;
            o_start_calc  <= 1'b0;
            o_logic_error <= 1'b0;
        end else begin
            state        <= next_state;
            o_addr_ready <= (state == ST_INPUT) && i_dims_valid;
            o_start_calc <= (state == ST_CHECK) && (next_state == ST_EXECUTE);

            // one allocation per input episode
            if (state == ST_INPUT) begin
                if (lif.alloc) begin
                    r_alloc_done <= 1'b1;
                    r_alloc_open <= 1'b1;
                end
                if (i_rx_done || lif.rollback) r_alloc_open <= 1'b0;
            end else begin
                r_alloc_done <= 1'b0;
                r_alloc_open <= 1'b0;
            end

            case (state)
                ST_IDLE: begin
                    o_logic_error <= 1'b0;
                    if (i_confirm && !i_sw[0])
                        r_retry_state <= i_sw[1] ? ST_SELECT_OP : ST_INPUT;
                end
                ST_SELECT_OP: begin
                    if (i_confirm) begin
                        r_op          <= op_e'(i_sw[7:5]);
                        r_stage       <= 1'b0;
                        o_logic_error <= 1'b0;
                    end
                end
                ST_GET_DIM: if (i_dims_valid) o_logic_error <= 1'b0;
                ST_FILTER:  if (!lif.hit) o_logic_error <= 1'b1; // unknown shape
                ST_GET_ID: begin
                    if (i_id_valid) o_logic_error <= !id_ok;
                    if (id_ok && need_second) r_stage <= 1'b1;
                end
                ST_CHECK:   if (!i_legal) o_logic_error <= 1'b1;
                default: ;
            endcase
        end
    end

    // payload registers
    always_ff @(posedge clk) begin
        if (lif.alloc) o_base_addr <= lif.slot_addr;
        if (state == ST_GET_DIM && i_dims_valid) r_shape <= i_dim;
        if (o_load1) o_op1_addr <= op_addr;
        if (o_load2) o_op2_addr <= op_addr;
        if (state == ST_CHECK) o_res_addr <= lif.slot_addr; // valid with start pulse
    end

    a_start_pulse: assert property (@(posedge clk) disable iff (!rst_n)
        o_start_calc |=> !o_start_calc);

endmodule

// ==== logic/operand_check.sv ====
`include "mat_config.svh"

module operand_check import ctrl_pkg::*, ledger_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  op_e    i_op,
    input  logic   i_load1,
    input  logic   i_load2,
    input  shape_t i_shape,
    output logic   o_legal,
    output shape_t o_res_shape
);

    shape_t op1;
    shape_t op2;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            op1 <= '0;
            op2 <= '0;
        end else begin
            if (i_load1) op1 <= i_shape;
            if (i_load2) op2 <= i_shape; // unused for transpose
        end
    end

    // legality and predicted result shape
    always_comb begin
        case (i_op)
            OP_TRANSPOSE: begin
                o_legal     = 1'b1;
                o_res_shape = '{m: op1.n, n: op1.m};
            end
            OP_ADD: begin
                o_legal     = (op1 == op2);
                o_res_shape = op1;
            end
            default: begin // matmul
                o_legal     = (op1.n == op2.m);
                o_res_shape = '{m: op1.m, n: op2.n};
            end
        endcase
    end

endmodule

// ==== logic/shape_ledger.sv ====
`include "mat_config.svh"

module shape_ledger import ledger_pkg::*; (
    input  logic            clk,
    input  logic            rst_n,
    ledger_if.ledger        lif,
    output lidx_t           o_types_count,
    output cnt_t            o_total_count
);

    localparam int PW = 2 * `MAT_DIM_W;

    // table storage
    shape_t tbl_shape [`MAT_MAX_TYPES];
    addr_t  tbl_start [`MAT_MAX_TYPES];
    logic   tbl_slot  [`MAT_MAX_TYPES]; // which half of the double buffer is next
    vcnt_t  tbl_cnt   [`MAT_MAX_TYPES];

    lidx_t          types_cnt;
    addr_t          free_ptr;
    logic [PW-1:0]  mat_size;
    logic           room;
    logic           upd;
    cnt_t           total;

    // rollback backups
    logic   bk_valid;
    logic   bk_new;
    lidx_t  bk_idx;
    addr_t  bk_free;
    vcnt_t  bk_cnt;

    // ==============================
    // lookup
    // ==============================
    always_comb begin
        lif.hit     = 1'b0;
        lif.hit_idx = '0;
        for (int i = 0; i < `MAT_MAX_TYPES; i++) begin
            if (lidx_t'(i) < types_cnt && tbl_shape[i] == lif.q_shape) begin
                lif.hit     = 1'b1;
                lif.hit_idx = lidx_t'(i); // last match wins
            end
        end
    end

    assign mat_size      = lif.q_shape.m * lif.q_shape.n;
    assign lif.hit_start = tbl_start[lif.hit_idx];
    assign lif.hit_cnt   = tbl_cnt[lif.hit_idx];
    assign lif.slot_addr = !lif.hit ? free_ptr :
                           tbl_slot[lif.hit_idx] ? lif.hit_start + mat_size[`MAT_ADDR_W-1:0] :
                           lif.hit_start;

    assign room = types_cnt < lidx_t'(`MAT_MAX_TYPES);
    assign upd  = lif.alloc | lif.commit;

    // ==============================
    // table updates
    // ==============================
    always_ff @(posedge clk) begin
        if (lif.rollback) begin
            if (bk_valid && !bk_new) begin
                tbl_slot[bk_idx] <= ~tbl_slot[bk_idx];
                tbl_cnt[bk_idx]  <= bk_cnt;
            end
        end else if (upd) begin
            if (lif.hit) begin
                tbl_slot[lif.hit_idx] <= ~tbl_slot[lif.hit_idx];
                if (lif.hit_cnt < 2'd2)
                    tbl_cnt[lif.hit_idx] <= lif.hit_cnt + 2'd1;
            end else if (room) begin
                tbl_shape[types_cnt] <= lif.q_shape;
                tbl_start[types_cnt] <= free_ptr;
                tbl_slot[types_cnt]  <= 1'b1;
                tbl_cnt[types_cnt]   <= 2'd1;
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            types_cnt <= '0;
            free_ptr  <= '0;
            bk_valid  <= 1'b0;
            bk_new    <= 1'b0;
            bk_idx    <= '0;
            bk_free   <= '0;
            bk_cnt    <= '0;
        end else begin
            if (lif.rollback) begin
                if (bk_valid && bk_new) begin
                    types_cnt <= types_cnt - 5'd1;
                    free_ptr  <= bk_free;
                end
                bk_valid <= 1'b0;
            end else if (upd && !lif.hit && room) begin
                types_cnt <= types_cnt + 5'd1;
                free_ptr  <= free_ptr + {mat_size[`MAT_ADDR_W-2:0], 1'b0}; // both slots
            end
            if (lif.alloc) begin
                bk_valid <= lif.hit | room; // full table allocates nothing
                bk_new   <= ~lif.hit;
                bk_idx   <= lif.hit_idx;
                bk_free  <= free_ptr;
                bk_cnt   <= lif.hit_cnt;
            end
        end
    end

    // status counts
    always_comb begin
        total = '0;
        for (int i = 0; i < `MAT_MAX_TYPES; i++) begin
            if (lidx_t'(i) < types_cnt)
                total = total + cnt_t'(tbl_cnt[i]);
        end
    end

    assign o_types_count = types_cnt;
    assign o_total_count = total;

    a_types_max: assert property (@(posedge clk) disable iff (!rst_n)
        types_cnt <= lidx_t'(`MAT_MAX_TYPES));

    // input and calc allocations come from different states
    a_alloc_commit: assert property (@(posedge clk) disable iff (!rst_n)
        !(lif.alloc && lif.commit));

endmodule

// ==== verif/tb_mat_ctrl.sv ====
module tb_mat_ctrl import ctrl_pkg::*, ledger_pkg::*;;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int         CLK_PERIOD      = 100;
    localparam int         WATCHDOG_CYCLES = 4000; // all tests use a few hundred cycles
    localparam logic [2:0] BTN_CONFIRM     = 3'b001;
    localparam logic [2:0] BTN_RETRY       = 3'b010;
    localparam logic [2:0] BTN_MENU        = 3'b100;

    logic        clk;
    logic        rst_n;
    logic [7:0]  i_sw;
    logic        i_btn_confirm;
    logic        i_btn_retry;
    logic        i_btn_menu;
    logic        i_dims_valid;
    dim_t        i_dim_m;
    dim_t        i_dim_n;
    logic        i_rx_done;
    logic        i_error_flag;
    logic        i_timeout;
    logic        i_id_valid;
    logic [7:0]  i_id_val;
    logic        i_calc_done;
    logic        o_en_input;
    logic [1:0]  o_task_mode;
    logic        o_addr_ready;
    addr_t       o_base_addr;
    logic        o_start_calc;
    op_e         o_op_code;
    addr_t       o_op1_addr;
    addr_t       o_op2_addr;
    addr_t       o_res_addr;
    ctrl_state_e o_state;
    logic        o_logic_error;
    lidx_t       o_types_count;
    cnt_t        o_total_count;
    int          start_pulses;

    mat_ctrl_top dut0 (.*);

    initial clk = 1'b0;
    always #(CLK_PERIOD / 2) clk = ~clk;

    // counts every cycle with the start strobe high
    always @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            start_pulses <= 0;
        else if (o_start_calc)
            start_pulses <= start_pulses + 1;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("watchdog timeout after %0d cycles", WATCHDOG_CYCLES);
        $display("Result: FAILED");
        $fatal(1, "simulation stopped by watchdog");
    end

    // ==============================
    // compare tasks
    // ==============================
    task automatic report_mismatch(input string msg);
        $display("Mismatch at %0d ns: %s", $time, msg);
        $display("Result: FAILED");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_addr(input string what, input addr_t got, input addr_t exp);
        if (got !== exp)
            report_mismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
    endtask

    task automatic check_state(input ctrl_state_e got, input ctrl_state_e exp);
        if (got !== exp)
            report_mismatch($sformatf("state is %s, expected %s", got.name(), exp.name()));
    endtask

    task automatic check_count(input string what, input cnt_t got, input cnt_t exp);
        if (got !== exp)
            report_mismatch($sformatf("%s is %0d, expected %0d", what, got, exp));
    endtask

    task automatic check_bit(input string what, input logic got, input logic exp);
        if (got !== exp)
            report_mismatch($sformatf("%s is %b, expected %b", what, got, exp));
    endtask

    task automatic check_op(input op_e got, input op_e exp);
        if (got !== exp)
            report_mismatch($sformatf("o_op_code is %0d, expected %0d", got, exp));
    endtask

    task automatic check_mode(input logic [1:0] got, input logic [1:0] exp);
        if (got !== exp)
            report_mismatch($sformatf("o_task_mode is %0d, expected %0d", got, exp));
    endtask

    // ==============================
    // stimulus helpers
    // ==============================
    task automatic wait_state(input ctrl_state_e target);
        while (o_state !== target)
            @(negedge clk);
    endtask

    task automatic press_button(input logic [2:0] which);
        {i_btn_menu, i_btn_retry, i_btn_confirm} = which;
        repeat (4) @(negedge clk);
        {i_btn_menu, i_btn_retry, i_btn_confirm} = 3'b000;
        repeat (3) @(negedge clk); // synchronizer back to low
    endtask

    task automatic begin_input();
        i_sw = 8'h00;
        press_button(BTN_CONFIRM);
        wait_state(ST_INPUT);
    endtask

    task automatic send_dims(input dim_t m, input dim_t n, input addr_t exp_addr);
        i_dim_m      = m;
        i_dim_n      = n;
        i_dims_valid = 1'b1;
        do @(negedge clk); while (!o_addr_ready);
        check_addr("o_base_addr", o_base_addr, exp_addr);
        i_dims_valid = 1'b0;
    endtask

    task automatic end_input();
        i_rx_done = 1'b1;
        @(negedge clk);
        i_rx_done = 1'b0;
        wait_state(ST_WAIT_DECISION);
    endtask

    task automatic return_idle();
        press_button(BTN_CONFIRM);
        check_state(o_state, ST_IDLE);
    endtask

    task automatic store_matrix(input dim_t m, input dim_t n, input addr_t exp_addr,
                                input cnt_t exp_total);
        begin_input();
        send_dims(m, n, exp_addr);
        check_count("o_total_count", o_total_count, exp_total);
        end_input();
        return_idle();
    endtask

    task automatic start_op(input op_e op);
        i_sw = {op, 3'b000, 2'b10};
        press_button(BTN_CONFIRM);
        wait_state(ST_SELECT_OP);
        press_button(BTN_CONFIRM);
        wait_state(ST_GET_DIM);
    endtask

    // one dims strobe in get_dim, returns after the filter step
    task automatic query_shape(input dim_t m, input dim_t n);
        wait_state(ST_GET_DIM);
        i_dim_m      = m;
        i_dim_n      = n;
        i_dims_valid = 1'b1;
        @(negedge clk);
        i_dims_valid = 1'b0;
        @(negedge clk);
    endtask

    task automatic pick_id(input logic [7:0] id);
        i_id_valid = 1'b1;
        i_id_val   = id;
        @(negedge clk);
        i_id_valid = 1'b0;
    endtask

    // ==============================
    // directed tests
    // ==============================
    task automatic test_reset();
        check_state(o_state, ST_IDLE);
        check_bit("o_en_input", o_en_input, 1'b0);
        check_bit("o_addr_ready", o_addr_ready, 1'b0);
        check_bit("o_start_calc", o_start_calc, 1'b0);
        check_bit("o_logic_error", o_logic_error, 1'b0);
        check_count("o_types_count", cnt_t'(o_types_count), 8'd0);
        check_count("o_total_count", o_total_count, 8'd0);
    endtask

    task automatic test_addresses();
        store_matrix(8'd2, 8'd3, 9'd0, 8'd1);  // miss, free pointer
        store_matrix(8'd2, 8'd3, 9'd6, 8'd2);  // slot bit 1, start + 2*3
        store_matrix(8'd2, 8'd3, 9'd0, 8'd2);  // slot bit 0, count held at 2
        store_matrix(8'd3, 8'd3, 9'd12, 8'd3); // free pointer 0 + 2*6
        check_count("o_types_count", cnt_t'(o_types_count), 8'd2);
    endtask

    task automatic test_rollback();
        begin_input();
        send_dims(8'd4, 8'd4, 9'd30); // 12 + 2*9
        check_count("o_types_count", cnt_t'(o_types_count), 8'd3);
        i_error_flag = 1'b1;
        @(negedge clk);
        i_error_flag = 1'b0;
        check_count("o_types_count", cnt_t'(o_types_count), 8'd2);
        end_input();
        press_button(BTN_RETRY);
        check_state(o_state, ST_INPUT);
        check_bit("o_en_input", o_en_input, 1'b1);
        check_mode(o_task_mode, 2'd0);
        send_dims(8'd2, 8'd2, 9'd30); // freed space reused
        check_count("o_types_count", cnt_t'(o_types_count), 8'd3);
        end_input();
        return_idle();
    endtask

    task automatic test_calc();
        int          pulses_before;
        int unsigned wait_cycles;
        pulses_before = start_pulses;
        start_op(OP_MATMUL);
        check_op(o_op_code, OP_MATMUL);
        check_bit("o_en_input", o_en_input, 1'b1);
        check_mode(o_task_mode, 2'd1);
        query_shape(8'd2, 8'd3);
        check_state(o_state, ST_GET_ID);
        check_mode(o_task_mode, 2'd2);
        pick_id(8'd1);
        check_state(o_state, ST_GET_DIM);
        check_addr("o_op1_addr", o_op1_addr, 9'd0); // 2x3 start + 0*6
        query_shape(8'd3, 8'd3);
        pick_id(8'd1);
        check_state(o_state, ST_CHECK);
        check_addr("o_op2_addr", o_op2_addr, 9'd12);
        @(negedge clk);
        check_state(o_state, ST_EXECUTE);
        check_bit("o_start_calc", o_start_calc, 1'b1);
        check_addr("o_res_addr", o_res_addr, 9'd6); // 2x3 slot bit is 1 again
        wait_cycles = $urandom_range(8, 1);
        repeat (wait_cycles) @(negedge clk);
        i_calc_done = 1'b1;
        @(negedge clk);
        i_calc_done = 1'b0;
        check_state(o_state, ST_WAIT_DECISION);
        check_count("start pulses", cnt_t'(start_pulses - pulses_before), 8'd1);
        check_count("o_total_count", o_total_count, 8'd4); // 2 + 1 + 1
        check_count("o_types_count", cnt_t'(o_types_count), 8'd3);
        return_idle();
    endtask

    task automatic test_logic_errors();
        start_op(OP_MATMUL);
        query_shape(8'd5, 8'd5); // unknown shape
        check_state(o_state, ST_GET_DIM);
        check_bit("o_logic_error", o_logic_error, 1'b1);
        query_shape(8'd2, 8'd3);
        check_state(o_state, ST_GET_ID);
        check_bit("o_logic_error", o_logic_error, 1'b0);
        pick_id(8'd0);
        check_state(o_state, ST_GET_ID);
        check_bit("o_logic_error", o_logic_error, 1'b1);
        pick_id(8'd1);
        check_state(o_state, ST_GET_DIM);
        check_bit("o_logic_error", o_logic_error, 1'b0);
        query_shape(8'd3, 8'd3);
        pick_id(8'd2); // only one 3x3 stored
        check_state(o_state, ST_GET_ID);
        check_bit("o_logic_error", o_logic_error, 1'b1);
        press_button(BTN_MENU);
        check_state(o_state, ST_IDLE);
    endtask

    task automatic test_add_check();
        start_op(OP_ADD);
        check_op(o_op_code, OP_ADD);
        query_shape(8'd2, 8'd3);
        pick_id(8'd1);
        query_shape(8'd3, 8'd3);
        pick_id(8'd1);
        check_state(o_state, ST_CHECK);
        check_bit("o_logic_error", o_logic_error, 1'b0);
        @(negedge clk);
        check_state(o_state, ST_SELECT_OP);
        check_bit("o_logic_error", o_logic_error, 1'b1);
        press_button(BTN_MENU);
        check_state(o_state, ST_IDLE);
    endtask

    task automatic test_timeout();
        begin_input();
        i_timeout = 1'b1;
        @(negedge clk);
        i_timeout = 1'b0;
        check_state(o_state, ST_ERROR);
        check_bit("o_en_input", o_en_input, 1'b0);
        return_idle();
    endtask

    initial begin
        void'($urandom(32'h56a8));
        rst_n         = 1'b0;
        i_sw          = 8'h00;
        i_btn_confirm = 1'b0;
        i_btn_retry   = 1'b0;
        i_btn_menu    = 1'b0;
        i_dims_valid  = 1'b0;
        i_dim_m       = '0;
        i_dim_n       = '0;
        i_rx_done     = 1'b0;
        i_error_flag  = 1'b0;
        i_timeout     = 1'b0;
        i_id_valid    = 1'b0;
        i_id_val      = 8'h00;
        i_calc_done   = 1'b0;
        repeat (4) @(negedge clk);
        rst_n = 1'b1;
        @(negedge clk);
        test_reset();
        test_addresses();
        test_rollback();
        test_calc();
        test_logic_errors();
        test_add_check();
        test_timeout();
        $display("Result: PASSED");
        $finish;
    end

endmodule
